/* bench/fe_mem_tb.sv */
`timescale 1ns/1ns

module fe_mem_tb
   import fe_mem_pkg::*;
();

   localparam int CLK_PERIOD   = 4;
   localparam int NUM_CYCLES   = 3000;
   localparam int DRAIN_CYCLES = 4;
   localparam int WATCHDOG_NS  = (NUM_CYCLES + DRAIN_CYCLES + 2) * CLK_PERIOD + 200;
   localparam int CACHE_LINES  = 1 << ICACHE_INDEX_WIDTH;
   localparam int OFF_HI_WIDTH = ICACHE_TAG_WIDTH - PTAG_WIDTH;

   logic                          clk_i = 1'b0;
   logic                          reset_i;
   logic                          cmd_v_i;
   logic [OP_WIDTH-1:0]           cmd_op_i;
   logic [VADDR_WIDTH-1:0]        cmd_vaddr_i;
   logic [PTAG_WIDTH-1:0]         cmd_fill_ptag_i;
   logic                          cmd_fill_u_i;
   logic                          cmd_fill_x_i;
   logic [PRIV_WIDTH-1:0]         priv_i;
   logic                          translation_en_i;
   logic                          poison_i;
   logic                          fill_v_i;
   logic [ICACHE_INDEX_WIDTH-1:0] fill_index_i;
   logic [ICACHE_TAG_WIDTH-1:0]   fill_tag_i;
   logic [INSTR_WIDTH-1:0]        fill_data_i;
   logic                          resp_v_o;
   logic [INSTR_WIDTH-1:0]        resp_data_o;
   logic                          resp_itlb_miss_o;
   logic                          resp_icache_miss_o;
   logic                          resp_page_fault_o;
   logic                          resp_access_fault_o;

   integer seed = 69;

   typedef struct packed {
      logic                        hit;
      logic [PTAG_WIDTH-1:0]       ptag;
      logic                        u;
      logic                        x;
      logic [VTAG_WIDTH-1:0]       vtag;
      logic                        line_v;
      logic [ICACHE_TAG_WIDTH-1:0] line_tag;
      logic [INSTR_WIDTH-1:0]      line_data;
      logic [OFF_HI_WIDTH-1:0]     off_hi;
   } lookup_t;

   typedef struct packed {
      int unsigned            due;  // cycle in which resp_v_o must be high
      logic [INSTR_WIDTH-1:0] data;
      logic                   itlb_miss;
      logic                   icache_miss;
      logic                   page_fault;
      logic                   access_fault;
   } resp_t;

   // ************************************************************
   // reference model state
   // ************************************************************

   logic                        m_tlb_v    [ITLB_ELS];
   logic [VTAG_WIDTH-1:0]       m_tlb_vtag [ITLB_ELS];
   logic [PTAG_WIDTH-1:0]       m_tlb_ptag [ITLB_ELS];
   logic                        m_tlb_u    [ITLB_ELS];
   logic                        m_tlb_x    [ITLB_ELS];
   logic [ITLB_PTR_WIDTH-1:0]   m_ptr;
   logic                        m_c_v      [CACHE_LINES];
   logic [ICACHE_TAG_WIDTH-1:0] m_c_tag    [CACHE_LINES];
   logic [INSTR_WIDTH-1:0]      m_c_data   [CACHE_LINES];
   lookup_t                     s1;        // fetch in its middle cycle
   logic                        s1_v;
   resp_t                       exp_q[$];
   logic [VADDR_WIDTH-1:0]      last_vaddr;
   int unsigned                 n_resp;

   always #(CLK_PERIOD/2) clk_i = ~clk_i;

   fe_mem_top i_fe_mem_top (
      .clk_i               (clk_i),
      .reset_i             (reset_i),
      .cmd_v_i             (cmd_v_i),
      .cmd_op_i            (cmd_op_i),
      .cmd_vaddr_i         (cmd_vaddr_i),
      .cmd_fill_ptag_i     (cmd_fill_ptag_i),
      .cmd_fill_u_i        (cmd_fill_u_i),
      .cmd_fill_x_i        (cmd_fill_x_i),
      .priv_i              (priv_i),
      .translation_en_i    (translation_en_i),
      .poison_i            (poison_i),
      .fill_v_i            (fill_v_i),
      .fill_index_i        (fill_index_i),
      .fill_tag_i          (fill_tag_i),
      .fill_data_i         (fill_data_i),
      .resp_v_o            (resp_v_o),
      .resp_data_o         (resp_data_o),
      .resp_itlb_miss_o    (resp_itlb_miss_o),
      .resp_icache_miss_o  (resp_icache_miss_o),
      .resp_page_fault_o   (resp_page_fault_o),
      .resp_access_fault_o (resp_access_fault_o)
   );

   function automatic logic [31:0] rand_word();
      rand_word = $random(seed);
   endfunction

   function automatic int unsigned rand_below(input int unsigned n);
      return rand_word() % n;
   endfunction

   function automatic bit chance(input int unsigned pct);
      return rand_below(100) < pct;
   endfunction

   function automatic logic [VTAG_WIDTH-1:0] vtag_of(input logic [VADDR_WIDTH-1:0] va);
      return va[VADDR_WIDTH-1:PAGE_OFFSET_WIDTH];
   endfunction

   function automatic logic [ICACHE_INDEX_WIDTH-1:0] index_of(input logic [VADDR_WIDTH-1:0] va);
      return va[ICACHE_INDEX_WIDTH+1:2];
   endfunction

   function automatic logic [OFF_HI_WIDTH-1:0] off_hi_of(input logic [VADDR_WIDTH-1:0] va);
      return va[PAGE_OFFSET_WIDTH-1:ICACHE_INDEX_WIDTH+2];
   endfunction

   function automatic int tlb_find(input logic [VTAG_WIDTH-1:0] vtag);
      int idx;
      idx = -1;
      for (int i = 0; i < ITLB_ELS; i++) begin
         if (m_tlb_v[i] && m_tlb_vtag[i] == vtag) begin
            idx = i;
         end
      end
      return idx;
   endfunction

   // a vtag that no valid entry holds keeps the TLB from double matching
   function automatic logic [VTAG_WIDTH-1:0] free_vtag();
      logic [VTAG_WIDTH-1:0] v;
      v = VTAG_WIDTH'(rand_below(16));
      while (tlb_find(v) >= 0) begin
         v = v + 1'b1;
      end
      return v;
   endfunction

   function automatic logic [PTAG_WIDTH-1:0] xlate_ptag(input logic [VTAG_WIDTH-1:0] vtag);
      int idx;
      idx = tlb_find(vtag);
      if (translation_en_i && idx >= 0) begin
         return m_tlb_ptag[idx];
      end else begin
         return {2'b00, vtag};  // identity page when untranslated
      end
   endfunction

   // ************************************************************
   // checks
   // ************************************************************

   task automatic stop_with_failure();
      $display("Verification failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_resp(
      input logic [INSTR_WIDTH-1:0] exp_data,
      input logic                   exp_itlb_miss,
      input logic                   exp_icache_miss,
      input logic                   exp_page_fault,
      input logic                   exp_access_fault
   );
      if (resp_v_o !== 1'b1) begin
         $display("no response at %0t ns although a fetch was due to complete", $time);
         stop_with_failure();
      end else if (resp_data_o !== exp_data) begin
         $display("** Error at %0t ns: resp_data_o is %h, expected %h",
                  $time, resp_data_o, exp_data);
         stop_with_failure();
      end else if (resp_itlb_miss_o !== exp_itlb_miss) begin
         $display("** Error at %0t ns: resp_itlb_miss_o is %b, expected %b",
                  $time, resp_itlb_miss_o, exp_itlb_miss);
         stop_with_failure();
      end else if (resp_icache_miss_o !== exp_icache_miss) begin
         $display("** Error at %0t ns: resp_icache_miss_o is %b, expected %b",
                  $time, resp_icache_miss_o, exp_icache_miss);
         stop_with_failure();
      end else if (resp_page_fault_o !== exp_page_fault) begin
         $display("** Error at %0t ns: resp_page_fault_o is %b, expected %b",
                  $time, resp_page_fault_o, exp_page_fault);
         stop_with_failure();
      end else if (resp_access_fault_o !== exp_access_fault) begin
         $display("** Error at %0t ns: resp_access_fault_o is %b, expected %b",
                  $time, resp_access_fault_o, exp_access_fault);
         stop_with_failure();
      end
   endtask

   task automatic check_idle();
      if (resp_v_o !== 1'b0) begin
         $display("response valid at %0t ns while no fetch was due to complete", $time);
         stop_with_failure();
      end
   endtask

   task automatic check_cycle(input int unsigned c);
      resp_t r;
      if (exp_q.size() > 0 && exp_q[0].due == c) begin
         r = exp_q.pop_front();
         check_resp(r.data, r.itlb_miss, r.icache_miss, r.page_fault, r.access_fault);
         n_resp++;
      end else begin
         check_idle();
      end
   endtask

   // ************************************************************
   // model update once the inputs of cycle c are driven
   // ************************************************************

   task automatic update_model(input int unsigned c);
      resp_t                 r;
      int                    idx;
      logic                  hit;
      logic                  chit;
      logic                  priv_bad;
      logic [PTAG_WIDTH-1:0] ptag;
      if (s1_v) begin  // retires with this cycle's status inputs
         hit      = !translation_en_i || s1.hit;
         ptag     = translation_en_i ? s1.ptag : {2'b00, s1.vtag};
         chit     = hit && s1.line_v && (s1.line_tag == {ptag, s1.off_hi});
         priv_bad = (priv_i == PRIV_S && s1.u) || (priv_i == PRIV_U && !s1.u);
         r.due          = c + 1;
         r.data         = chit ? s1.line_data : '0;
         r.itlb_miss    = !hit;
         r.icache_miss  = !chit;
         r.page_fault   = translation_en_i && hit && (!s1.x || priv_bad);
         r.access_fault = hit && (ptag >= PMA_PTAG_LIMIT);
         if (!poison_i) begin
            exp_q.push_back(r);
         end
      end
      s1_v = cmd_v_i && (cmd_op_i == OP_FETCH);
      if (s1_v) begin  // lookup sees state before this cycle's updates
         idx          = tlb_find(vtag_of(cmd_vaddr_i));
         s1.hit       = idx >= 0;
         s1.ptag      = (idx >= 0) ? m_tlb_ptag[idx] : '0;
         s1.u         = (idx >= 0) ? m_tlb_u[idx] : 1'b0;
         s1.x         = (idx >= 0) ? m_tlb_x[idx] : 1'b0;
         s1.vtag      = vtag_of(cmd_vaddr_i);
         s1.line_v    = m_c_v[index_of(cmd_vaddr_i)];
         s1.line_tag  = m_c_tag[index_of(cmd_vaddr_i)];
         s1.line_data = m_c_data[index_of(cmd_vaddr_i)];
         s1.off_hi    = off_hi_of(cmd_vaddr_i);
         last_vaddr   = cmd_vaddr_i;
      end
      if (cmd_v_i && cmd_op_i == OP_TLB_FILL) begin
         m_tlb_v[m_ptr]    = 1'b1;
         m_tlb_vtag[m_ptr] = vtag_of(cmd_vaddr_i);
         m_tlb_ptag[m_ptr] = cmd_fill_ptag_i;
         m_tlb_u[m_ptr]    = cmd_fill_u_i;
         m_tlb_x[m_ptr]    = cmd_fill_x_i;
         m_ptr             = m_ptr + 1'b1;  // round robin victim
      end
      if (cmd_v_i && cmd_op_i == OP_TLB_FENCE) begin
         for (int i = 0; i < ITLB_ELS; i++) begin
            m_tlb_v[i] = 1'b0;
         end
      end
      if (fill_v_i) begin
         m_c_v[fill_index_i]    = 1'b1;
         m_c_tag[fill_index_i]  = fill_tag_i;
         m_c_data[fill_index_i] = fill_data_i;
      end
   endtask

   // ************************************************************
   // stimulus in phases of biased operations
   // ************************************************************

   task automatic drive_cycle(input int unsigned c);
      int unsigned           ph;
      int unsigned           r;
      int unsigned           fill_pct;
      int unsigned           fence_pct;
      int                    j;
      logic [VTAG_WIDTH-1:0] vtag;
      ph = (c < 40) ? 0 : (c < 600) ? 1 : (c < 1100) ? 2 : (c < 1700) ? 3 : (c < 2300) ? 4 : 5;
      fill_pct  = (ph == 0) ? 40 : (ph == 1) ? 3 : (ph == 2) ? 15 : 8;
      fence_pct = (ph == 2) ? 5 : (ph >= 3) ? 2 : 0;
      r = rand_below(100);
      cmd_v_i  = (c < NUM_CYCLES) && (r >= 10 || ph == 0);  // 10% idle after preload
      cmd_op_i = (r < 10 + fill_pct) ? OP_TLB_FILL :
                 (r < 10 + fill_pct + fence_pct) ? OP_TLB_FENCE : OP_FETCH;
      if (cmd_op_i == OP_TLB_FILL) begin
         cmd_vaddr_i = {free_vtag(), 12'(rand_word())};
      end else if (chance(30)) begin
         cmd_vaddr_i = last_vaddr;  // refetch that often follows a refill
      end else begin
         j    = rand_below(ITLB_ELS);
         vtag = (m_tlb_v[j] && chance(75)) ? m_tlb_vtag[j] : VTAG_WIDTH'(rand_below(16));
         cmd_vaddr_i = {vtag, 4'(rand_below(2)), 2'b00, 4'(rand_below(16)), 2'(rand_below(4))};
      end
      cmd_fill_ptag_i  = (ph >= 3) ? PTAG_WIDTH'(rand_word()) : {1'b0, 9'(rand_word())};
      cmd_fill_u_i     = (ph < 3) || chance(50);
      cmd_fill_x_i     = (ph < 3) || chance(70);
      priv_i           = (ph >= 3) ? PRIV_WIDTH'(rand_word()) : PRIV_U;
      translation_en_i = (ph < 4) || chance(60);
      poison_i         = (ph == 5) && chance(25);
      fill_v_i         = (c < NUM_CYCLES) && (ph == 0 || chance(25));
      if (chance(50)) begin
         fill_index_i = index_of(last_vaddr);
         fill_tag_i   = {xlate_ptag(vtag_of(last_vaddr)), off_hi_of(last_vaddr)};
      end else begin
         j            = rand_below(ITLB_ELS);
         fill_index_i = ICACHE_INDEX_WIDTH'(rand_below(16));
         fill_tag_i   = {m_tlb_ptag[j], 4'(rand_below(2))};
      end
      fill_data_i = rand_word();
      update_model(c);
   endtask

   initial begin
      reset_i          = 1'b1;
      cmd_v_i          = 1'b0;
      cmd_op_i         = OP_FETCH;
      cmd_vaddr_i      = '0;
      cmd_fill_ptag_i  = '0;
      cmd_fill_u_i     = 1'b0;
      cmd_fill_x_i     = 1'b0;
      priv_i           = PRIV_U;
      translation_en_i = 1'b1;
      poison_i         = 1'b0;
      fill_v_i         = 1'b0;
      fill_index_i     = '0;
      fill_tag_i       = '0;
      fill_data_i      = '0;
      for (int i = 0; i < ITLB_ELS; i++) begin
         m_tlb_v[i]    = 1'b0;
         m_tlb_vtag[i] = '0;
         m_tlb_ptag[i] = '0;
         m_tlb_u[i]    = 1'b0;
         m_tlb_x[i]    = 1'b0;
      end
      for (int i = 0; i < CACHE_LINES; i++) begin
         m_c_v[i]    = 1'b0;
         m_c_tag[i]  = '0;
         m_c_data[i] = '0;
      end
      m_ptr      = '0;
      s1_v       = 1'b0;
      last_vaddr = '0;
      n_resp     = 0;
      repeat (2) @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      for (int unsigned c = 0; c < NUM_CYCLES + DRAIN_CYCLES; c++) begin
         check_cycle(c);  // outputs settled since the last edge
         drive_cycle(c);
         @(posedge clk_i);
         #1;
      end
      $display("%0d responses checked", n_resp);
      $display("Verification passed");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns before the test sequence ended", WATCHDOG_NS);
      stop_with_failure();
   end

endmodule

/* design/fe_cmd_decode.sv */
`timescale 1ns/1ns

module fe_cmd_decode
   import fe_mem_pkg::*;
(
   input  logic                clk_i,
   input  logic                reset_i,
   input  logic                cmd_v_i,
   input  logic [OP_WIDTH-1:0] cmd_op_i,
   output logic                fetch_v_o,
   output logic                fill_v_o,
   output logic                fence_v_o,
   output logic [ITLB_ELS-1:0] fill_sel_o
);

   logic [ITLB_PTR_WIDTH-1:0] repl_ptr_r;  // next victim entry

   assign fetch_v_o = cmd_v_i & (cmd_op_i == OP_FETCH);
   assign fill_v_o  = cmd_v_i & (cmd_op_i == OP_TLB_FILL);
   assign fence_v_o = cmd_v_i & (cmd_op_i == OP_TLB_FENCE);

   // pointer survives a fence
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         repl_ptr_r <= '0;
      end else if (fill_v_o) begin
         repl_ptr_r <= repl_ptr_r + 1'b1;  // wraps at ITLB_ELS
      end
   end

   always_comb begin
      fill_sel_o             = '0;
      fill_sel_o[repl_ptr_r] = 1'b1;  // one-hot of victim
   end

   a_no_illegal_op : assert property (
      @(posedge clk_i) disable iff (reset_i)
      cmd_v_i |-> (cmd_op_i != 2'd3)
   ) else $error("illegal command opcode accepted");

endmodule

/* design/fe_mem_pkg.sv */
package fe_mem_pkg;

   // ************************************************************
   // address split
   // ************************************************************

   localparam int VADDR_WIDTH       = 20;
   localparam int PAGE_OFFSET_WIDTH = 12;
   localparam int VTAG_WIDTH        = 8;   // vaddr[19:12]
   localparam int PTAG_WIDTH        = 10;  // physical page number

   // ************************************************************
   // itlb
   // ************************************************************

   localparam int ITLB_ELS       = 4;
   localparam int ITLB_PTR_WIDTH = 2;

   // ************************************************************
   // icache
   // ************************************************************

   localparam int ICACHE_INDEX_WIDTH = 6;   // vaddr[7:2]
   localparam int ICACHE_TAG_WIDTH   = 14;  // {ptag, vaddr[11:8]}
   localparam int INSTR_WIDTH        = 32;

   // ************************************************************
   // command opcodes
   // ************************************************************

   localparam int OP_WIDTH = 2;

   localparam logic [OP_WIDTH-1:0] OP_FETCH     = 2'd0;
   localparam logic [OP_WIDTH-1:0] OP_TLB_FILL  = 2'd1;
   localparam logic [OP_WIDTH-1:0] OP_TLB_FENCE = 2'd2;
   // opcode 3 is illegal

   // ************************************************************
   // privilege modes
   // ************************************************************

   localparam int PRIV_WIDTH = 2;

   localparam logic [PRIV_WIDTH-1:0] PRIV_U = 2'd0;
   localparam logic [PRIV_WIDTH-1:0] PRIV_S = 2'd1;
   localparam logic [PRIV_WIDTH-1:0] PRIV_M = 2'd3;

   // ************************************************************
   // memory map
   // ************************************************************

   // pages from here up are non-executable i/o space
   localparam logic [PTAG_WIDTH-1:0] PMA_PTAG_LIMIT = 10'd512;

endpackage

/* design/fe_mem_resp.sv */
`timescale 1ns/1ns

module fe_mem_resp
   import fe_mem_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  fetch_v_i,
   input  logic                  poison_i,
   input  logic [PRIV_WIDTH-1:0] priv_i,
   input  logic                  translation_en_i,
   input  logic                  tlb_miss_i,
   input  logic                  tlb_hit_i,
   input  logic [PTAG_WIDTH-1:0] ptag_i,
   input  logic                  u_i,
   input  logic                  x_i,
   input  logic                  icache_hit_i,
   input  logic [INSTR_WIDTH-1:0] icache_data_i,
   output logic                  resp_v_o,
   output logic [INSTR_WIDTH-1:0] resp_data_o,
   output logic                  resp_itlb_miss_o,
   output logic                  resp_icache_miss_o,
   output logic                  resp_page_fault_o,
   output logic                  resp_access_fault_o
);

   logic fetch_v_r;  // fetch sitting in stage 1
   logic priv_fault;
   logic page_fault;
   logic access_fault;

   assign priv_fault   = ((priv_i == PRIV_S) & u_i) | ((priv_i == PRIV_U) & ~u_i);
   assign page_fault   = translation_en_i & tlb_hit_i & (~x_i | priv_fault);
   assign access_fault = (ptag_i >= PMA_PTAG_LIMIT) & ~tlb_miss_i;  // i/o pages

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         fetch_v_r <= 1'b0;
         resp_v_o  <= 1'b0;
      end else begin
         fetch_v_r <= fetch_v_i;
         resp_v_o  <= fetch_v_r & ~poison_i;  // late kill
      end
   end

   always_ff @(posedge clk_i) begin
      if (fetch_v_r) begin
         resp_data_o         <= icache_hit_i ? icache_data_i : '0;
         resp_itlb_miss_o    <= tlb_miss_i;
         resp_icache_miss_o  <= ~icache_hit_i;
         resp_page_fault_o   <= page_fault;
         resp_access_fault_o <= access_fault;
      end
   end

   // a response needs an itlb lookup in stage 1 that was not poisoned
   a_resp_origin : assert property (
      @(posedge clk_i) disable iff (reset_i)
      resp_v_o |-> $past((tlb_hit_i || tlb_miss_i) && !poison_i)
   ) else $error("response without an unpoisoned itlb lookup in the cycle before");

endmodule

/* design/fe_mem_top.sv */
`timescale 1ns/1ns

module fe_mem_top
   import fe_mem_pkg::*;
(
   input  logic                          clk_i,
   input  logic                          reset_i,
   // command port
   input  logic                          cmd_v_i,
   input  logic [OP_WIDTH-1:0]           cmd_op_i,
   input  logic [VADDR_WIDTH-1:0]        cmd_vaddr_i,
   input  logic [PTAG_WIDTH-1:0]         cmd_fill_ptag_i,
   input  logic                          cmd_fill_u_i,
   input  logic                          cmd_fill_x_i,
   // status
   input  logic [PRIV_WIDTH-1:0]         priv_i,
   input  logic                          translation_en_i,
   input  logic                          poison_i,
   // cache fill port
   input  logic                          fill_v_i,
   input  logic [ICACHE_INDEX_WIDTH-1:0] fill_index_i,
   input  logic [ICACHE_TAG_WIDTH-1:0]   fill_tag_i,
   input  logic [INSTR_WIDTH-1:0]        fill_data_i,
   // response port
   output logic                          resp_v_o,
   output logic [INSTR_WIDTH-1:0]        resp_data_o,
   output logic                          resp_itlb_miss_o,
   output logic                          resp_icache_miss_o,
   output logic                          resp_page_fault_o,
   output logic                          resp_access_fault_o
);

   logic                                fetch_v;
   logic                                tlb_fill_v;
   logic                                fence_v;
   logic [ITLB_ELS-1:0]                 fill_sel;
   logic [ITLB_ELS-1:0]                 match;
   logic [ITLB_ELS-1:0][PTAG_WIDTH-1:0] entry_ptag;
   logic [ITLB_ELS-1:0]                 entry_u;
   logic [ITLB_ELS-1:0]                 entry_x;
   logic [PTAG_WIDTH-1:0]               ptag;
   logic                                tlb_u;
   logic                                tlb_x;
   logic                                tlb_hit;
   logic                                tlb_miss;
   logic [INSTR_WIDTH-1:0]              icache_data;
   logic                                icache_hit;

   wire [VTAG_WIDTH-1:0] vtag = cmd_vaddr_i[VADDR_WIDTH-1:PAGE_OFFSET_WIDTH];

   fe_cmd_decode i_fe_cmd_decode (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .cmd_v_i    (cmd_v_i),
      .cmd_op_i   (cmd_op_i),
      .fetch_v_o  (fetch_v),
      .fill_v_o   (tlb_fill_v),
      .fence_v_o  (fence_v),
      .fill_sel_o (fill_sel)
   );

   for (genvar i = 0; i < ITLB_ELS; i++) begin : g_itlb
      itlb_entry i_itlb_entry (
         .clk_i       (clk_i),
         .reset_i     (reset_i),
         .fence_i     (fence_v),
         .fill_i      (tlb_fill_v & fill_sel[i]),  // victim only
         .vtag_i      (vtag),
         .fill_ptag_i (cmd_fill_ptag_i),
         .fill_u_i    (cmd_fill_u_i),
         .fill_x_i    (cmd_fill_x_i),
         .match_o     (match[i]),
         .ptag_o      (entry_ptag[i]),
         .u_o         (entry_u[i]),
         .x_o         (entry_x[i])
      );
   end

   itlb_match i_itlb_match (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .fetch_v_i        (fetch_v),
      .translation_en_i (translation_en_i),
      .match_i          (match),
      .entry_ptag_i     (entry_ptag),
      .entry_u_i        (entry_u),
      .entry_x_i        (entry_x),
      .vtag_i           (vtag),
      .ptag_o           (ptag),
      .u_o              (tlb_u),
      .x_o              (tlb_x),
      .hit_o            (tlb_hit),
      .miss_o           (tlb_miss)
   );

   icache_store i_icache_store (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .fetch_v_i    (fetch_v),
      .index_i      (cmd_vaddr_i[ICACHE_INDEX_WIDTH+1:2]),
      .offset_hi_i  (cmd_vaddr_i[PAGE_OFFSET_WIDTH-1:ICACHE_INDEX_WIDTH+2]),
      .fill_v_i     (fill_v_i),
      .fill_index_i (fill_index_i),
      .fill_tag_i   (fill_tag_i),
      .fill_data_i  (fill_data_i),
      .ptag_i       (ptag),
      .ptag_v_i     (tlb_hit),
      .data_o       (icache_data),
      .hit_o        (icache_hit)
   );

   fe_mem_resp i_fe_mem_resp (
      .clk_i               (clk_i),
      .reset_i             (reset_i),
      .fetch_v_i           (fetch_v),
      .poison_i            (poison_i),
      .priv_i              (priv_i),
      .translation_en_i    (translation_en_i),
      .tlb_miss_i          (tlb_miss),
      .tlb_hit_i           (tlb_hit),
      .ptag_i              (ptag),
      .u_i                 (tlb_u),
      .x_i                 (tlb_x),
      .icache_hit_i        (icache_hit),
      .icache_data_i       (icache_data),
      .resp_v_o            (resp_v_o),
      .resp_data_o         (resp_data_o),
      .resp_itlb_miss_o    (resp_itlb_miss_o),
      .resp_icache_miss_o  (resp_icache_miss_o),
      .resp_page_fault_o   (resp_page_fault_o),
      .resp_access_fault_o (resp_access_fault_o)
   );

endmodule

/* design/icache_store.sv */
`timescale 1ns/1ns

module icache_store
   import fe_mem_pkg::*;
(
   input  logic                                         clk_i,
   input  logic                                         reset_i,
   input  logic                                         fetch_v_i,
   input  logic [ICACHE_INDEX_WIDTH-1:0]                index_i,
   input  logic [ICACHE_TAG_WIDTH-PTAG_WIDTH-1:0]       offset_hi_i,
   input  logic                                         fill_v_i,
   input  logic [ICACHE_INDEX_WIDTH-1:0]                fill_index_i,
   input  logic [ICACHE_TAG_WIDTH-1:0]                  fill_tag_i,
   input  logic [INSTR_WIDTH-1:0]                       fill_data_i,
   input  logic [PTAG_WIDTH-1:0]                        ptag_i,
   input  logic                                         ptag_v_i,
   output logic [INSTR_WIDTH-1:0]                       data_o,
   output logic                                         hit_o
);

   // ************************************************************
   // line arrays
   // ************************************************************

   logic [(1<<ICACHE_INDEX_WIDTH)-1:0] valid_r;
   logic [ICACHE_TAG_WIDTH-1:0]        tag_mem  [0:(1<<ICACHE_INDEX_WIDTH)-1];
   logic [INSTR_WIDTH-1:0]             data_mem [0:(1<<ICACHE_INDEX_WIDTH)-1];

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_r <= '0;
      end else if (fill_v_i) begin
         valid_r[fill_index_i] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_v_i) begin
         tag_mem[fill_index_i]  <= fill_tag_i;
         data_mem[fill_index_i] <= fill_data_i;
      end
   end

   // ************************************************************
   // stage 0 read, stage 1 compare
   // ************************************************************

   logic                                   line_v_r;
   logic [ICACHE_TAG_WIDTH-1:0]            line_tag_r;
   logic [INSTR_WIDTH-1:0]                 line_data_r;
   logic [ICACHE_TAG_WIDTH-PTAG_WIDTH-1:0] offset_hi_r;

   // read sees the arrays before a same-cycle fill lands
   always_ff @(posedge clk_i) begin
      if (fetch_v_i) begin
         line_v_r    <= valid_r[index_i];
         line_tag_r  <= tag_mem[index_i];
         line_data_r <= data_mem[index_i];
         offset_hi_r <= offset_hi_i;
      end
   end

   assign hit_o  = ptag_v_i & line_v_r & (line_tag_r == {ptag_i, offset_hi_r});
   assign data_o = line_data_r;

endmodule

/* design/itlb_entry.sv */
`timescale 1ns/1ns

module itlb_entry
   import fe_mem_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  fence_i,
   input  logic                  fill_i,
   input  logic [VTAG_WIDTH-1:0] vtag_i,
   input  logic [PTAG_WIDTH-1:0] fill_ptag_i,
   input  logic                  fill_u_i,
   input  logic                  fill_x_i,
   output logic                  match_o,
   output logic [PTAG_WIDTH-1:0] ptag_o,
   output logic                  u_o,
   output logic                  x_o
);

   logic                  valid_r;
   logic [VTAG_WIDTH-1:0] vtag_r;
   logic [PTAG_WIDTH-1:0] ptag_r;
   logic                  u_r;
   logic                  x_r;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_r <= 1'b0;
      end else if (fence_i) begin
         valid_r <= 1'b0;  // fence drops every translation
      end else if (fill_i) begin
         valid_r <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_i) begin
         vtag_r <= vtag_i;  // fill vtag rides on the command address
         ptag_r <= fill_ptag_i;
         u_r    <= fill_u_i;
         x_r    <= fill_x_i;
      end
   end

   assign match_o = valid_r & (vtag_r == vtag_i);
   assign ptag_o  = ptag_r;
   assign u_o     = u_r;
   assign x_o     = x_r;

endmodule

/* design/itlb_match.sv */
`timescale 1ns/1ns

module itlb_match
   import fe_mem_pkg::*;
(
   input  logic                                clk_i,
   input  logic                                reset_i,
   input  logic                                fetch_v_i,
   input  logic                                translation_en_i,
   input  logic [ITLB_ELS-1:0]                 match_i,
   input  logic [ITLB_ELS-1:0][PTAG_WIDTH-1:0] entry_ptag_i,
   input  logic [ITLB_ELS-1:0]                 entry_u_i,
   input  logic [ITLB_ELS-1:0]                 entry_x_i,
   input  logic [VTAG_WIDTH-1:0]               vtag_i,
   output logic [PTAG_WIDTH-1:0]               ptag_o,
   output logic                                u_o,
   output logic                                x_o,
   output logic                                hit_o,
   output logic                                miss_o
);

   logic                  fetch_v_r;
   logic [ITLB_ELS-1:0]   match_r;
   logic [VTAG_WIDTH-1:0] vtag_r;
   logic [PTAG_WIDTH-1:0] sel_ptag;
   logic                  any_match;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         fetch_v_r <= 1'b0;
         match_r   <= '0;
      end else begin
         fetch_v_r <= fetch_v_i;
         match_r   <= match_i;
      end
   end

   always_ff @(posedge clk_i) begin
      vtag_r <= vtag_i;
   end

   // and-or mux relies on at most one bit of match_r set
   always_comb begin
      sel_ptag = '0;
      u_o      = 1'b0;
      x_o      = 1'b0;
      for (int i = 0; i < ITLB_ELS; i++) begin
         sel_ptag = sel_ptag | ({PTAG_WIDTH{match_r[i]}} & entry_ptag_i[i]);
         u_o      = u_o | (match_r[i] & entry_u_i[i]);
         x_o      = x_o | (match_r[i] & entry_x_i[i]);
      end
   end

   assign any_match = |match_r;
   assign ptag_o    = translation_en_i ? sel_ptag : PTAG_WIDTH'(vtag_r);  // identity map when off
   assign hit_o     = fetch_v_r & (any_match | ~translation_en_i);
   assign miss_o    = fetch_v_r & ~any_match & translation_en_i;

   a_one_match : assert property (
      @(posedge clk_i) disable iff (reset_i)
      fetch_v_r |-> $onehot0(match_r)
   ) else $error("itlb has more than one entry matching a vtag");

endmodule

/* run.sh */
#!/usr/bin/env bash
# compile and run the fetch memory stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ns \
   --top-module fe_mem_tb -f sim.f -o fe_mem_sim

./obj_dir/fe_mem_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
   echo "simulation reported a failure, see sim.log"
   exit 1
fi
if ! grep -q "Verification passed" sim.log; then
   echo "simulation ended without a result, see sim.log"
   exit 1
fi
echo "simulation clean"

/* sim.f */
design/fe_mem_pkg.sv
design/fe_cmd_decode.sv
design/itlb_entry.sv
design/itlb_match.sv
design/icache_store.sv
design/fe_mem_resp.sv
design/fe_mem_top.sv
bench/fe_mem_tb.sv
